//--- design/lagd_mem_pkg.sv
/*
 * Shared localparams of the banked scratchpad
 * Bank count, narrow and wide port widths, in-bank addressing
 * and the reset value of the narrow/wide arbitration bit
 */
`default_nettype none

package lagd_mem_pkg;

    // ==================================================
    // Bank organisation
    // ==================================================
    // One narrow port per bank
    localparam int unsigned NumNarrowBanks = 4;

    // Port and bank data widths
    localparam int unsigned NarrowDataWidth = 32;
    localparam int unsigned WideDataWidth = 64;

    // Banks covered by one wide port
    localparam int unsigned NarrowPerWide = WideDataWidth / NarrowDataWidth;
    // Wide ports, one per bank group
    localparam int unsigned NumWideBanks = NumNarrowBanks / NarrowPerWide;

    // Byte enables
    localparam int unsigned NarrowStrbWidth = NarrowDataWidth / 8;
    localparam int unsigned WideStrbWidth = WideDataWidth / 8;

    // ==================================================
    // Addressing and arbitration
    // ==================================================
    // Word index inside one bank
    localparam int unsigned InBankAddrWidth = 6;
    localparam int unsigned BankWords = 2 ** InBankAddrWidth;

    // Narrow side wins the first conflict after reset
    localparam logic ArbNarrowFirst = 1'b1;

endpackage

`default_nettype wire

//--- design/mem_bank.sv
/*
 * Single-port synchronous SRAM bank
 * Byte-enabled writes, read data one cycle after the request
 */
`timescale 1ns/10ps
`default_nettype none

module mem_bank
    import lagd_mem_pkg::*;
(
    input  wire                         clk_i,
    input  wire                         rst_ni,
    input  wire                         req_i,
    input  wire                         we_i,
    input  wire [InBankAddrWidth-1:0]   addr_i,
    input  wire [NarrowDataWidth-1:0]   wdata_i,
    input  wire [NarrowStrbWidth-1:0]   be_i,
    output logic [NarrowDataWidth-1:0]  rdata_o
);

    // Storage array
    logic [NarrowDataWidth-1:0] mem_q [BankWords];

    // Byte-wise write, only enabled lanes change
    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            for (int b = 0; b < NarrowStrbWidth; b++) begin
                if (be_i[b]) begin
                    mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    // Read data register, zero on a write response, held when idle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_o <= '0;
        end else if (req_i) begin
            rdata_o <= we_i ? '0 : mem_q[addr_i];
        end
    end

endmodule

`default_nettype wire

//--- design/wide_to_narrow_splitter.sv
/*
 * Wide-to-narrow request splitter
 * Cuts one wide request into per-lane bank requests and merges
 * the lane read data into one wide response with its own valid
 */
`timescale 1ns/10ps
`default_nettype none

module wide_to_narrow_splitter
    import lagd_mem_pkg::*;
(
    input  wire                                             clk_i,
    input  wire                                             rst_ni,
    // Wide request side
    input  wire                                             wide_valid_i,
    input  wire                                             wide_ready_i,
    input  wire                                             wide_we_i,
    input  wire [InBankAddrWidth-1:0]                       wide_addr_i,
    input  wire [WideDataWidth-1:0]                         wide_wdata_i,
    input  wire [WideStrbWidth-1:0]                         wide_be_i,
    output logic                                            wide_rvalid_o,
    output logic [WideDataWidth-1:0]                        wide_rdata_o,
    // Lane side, one narrow request per covered bank
    output logic [NarrowPerWide-1:0]                        lane_we_o,
    output logic [NarrowPerWide-1:0][InBankAddrWidth-1:0]   lane_addr_o,
    output logic [NarrowPerWide-1:0][NarrowDataWidth-1:0]   lane_wdata_o,
    output logic [NarrowPerWide-1:0][NarrowStrbWidth-1:0]   lane_be_o,
    input  wire  [NarrowPerWide-1:0][NarrowDataWidth-1:0]   lane_rdata_i
);

    // ==================================================
    // Request splitting
    // ==================================================
    for (genvar k = 0; k < NarrowPerWide; k++) begin : gen_lane
        // Same word index in every bank of the group
        assign lane_we_o[k] = wide_we_i;
        assign lane_addr_o[k] = wide_addr_i;
        // Lane k takes its own slice of data and byte enables
        assign lane_wdata_o[k] = wide_wdata_i[k*NarrowDataWidth +: NarrowDataWidth];
        assign lane_be_o[k] = wide_be_i[k*NarrowStrbWidth +: NarrowStrbWidth];
        // Lane 0 ends up in the low half of the wide word
        assign wide_rdata_o[k*NarrowDataWidth +: NarrowDataWidth] = lane_rdata_i[k];
    end

    // ==================================================
    // Response valid
    // ==================================================
    // Banks answer one cycle after acceptance
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wide_rvalid_o <= 1'b0;
        end else begin
            wide_rvalid_o <= wide_valid_i && wide_ready_i;
        end
    end

endmodule

`default_nettype wire

//--- design/wide_narrow_arbiter.sv
/*
 * Narrow/wide round-robin arbiter for the banked scratchpad
 * Toggling priority bit, per-group conflict detection, bank request
 * muxing and one-cycle routing of bank read data to the granted side
 */
`timescale 1ns/10ps
`default_nettype none

module wide_narrow_arbiter
    import lagd_mem_pkg::*;
(
    input  wire                                             clk_i,
    input  wire                                             rst_ni,
    // Narrow ports
    input  wire  [NumNarrowBanks-1:0]                       narrow_valid_i,
    input  wire  [NumNarrowBanks-1:0]                       narrow_we_i,
    input  wire  [NumNarrowBanks-1:0][InBankAddrWidth-1:0]  narrow_addr_i,
    input  wire  [NumNarrowBanks-1:0][NarrowDataWidth-1:0]  narrow_wdata_i,
    input  wire  [NumNarrowBanks-1:0][NarrowStrbWidth-1:0]  narrow_be_i,
    output logic [NumNarrowBanks-1:0]                       narrow_ready_o,
    output logic [NumNarrowBanks-1:0]                       narrow_rvalid_o,
    output logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0]  narrow_rdata_o,
    // Wide ports
    input  wire  [NumWideBanks-1:0]                         wide_valid_i,
    input  wire  [NumWideBanks-1:0]                         wide_we_i,
    input  wire  [NumWideBanks-1:0][InBankAddrWidth-1:0]    wide_addr_i,
    input  wire  [NumWideBanks-1:0][WideDataWidth-1:0]      wide_wdata_i,
    input  wire  [NumWideBanks-1:0][WideStrbWidth-1:0]      wide_be_i,
    output logic [NumWideBanks-1:0]                         wide_ready_o,
    output logic [NumWideBanks-1:0]                         wide_rvalid_o,
    output logic [NumWideBanks-1:0][WideDataWidth-1:0]      wide_rdata_o,
    // Bank side
    output logic [NumNarrowBanks-1:0]                       bank_req_o,
    output logic [NumNarrowBanks-1:0]                       bank_we_o,
    output logic [NumNarrowBanks-1:0][InBankAddrWidth-1:0]  bank_addr_o,
    output logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0]  bank_wdata_o,
    output logic [NumNarrowBanks-1:0][NarrowStrbWidth-1:0]  bank_be_o,
    input  wire  [NumNarrowBanks-1:0][NarrowDataWidth-1:0]  bank_rdata_i
);

    // Priority bit, 1 lets the narrow side win a conflict
    logic arb_narrow_q;

    // Per-group arbitration state
    logic [NumWideBanks-1:0] narrow_any;
    logic [NumWideBanks-1:0] conflict;
    logic [NumWideBanks-1:0] wide_ready;
    logic [NumWideBanks-1:0] wide_grant;

    // Per-bank grants and the side accepted last cycle
    logic [NumNarrowBanks-1:0] narrow_ready;
    logic [NumNarrowBanks-1:0] narrow_grant;
    logic [NumNarrowBanks-1:0] wide_lane_grant;
    logic [NumNarrowBanks-1:0] narrow_sel_q;
    logic [NumNarrowBanks-1:0] wide_sel_q;

    // Lane requests and responses of the splitters
    logic [NumWideBanks-1:0][NarrowPerWide-1:0]                       split_we;
    logic [NumWideBanks-1:0][NarrowPerWide-1:0][InBankAddrWidth-1:0]  split_addr;
    logic [NumWideBanks-1:0][NarrowPerWide-1:0][NarrowDataWidth-1:0]  split_wdata;
    logic [NumWideBanks-1:0][NarrowPerWide-1:0][NarrowStrbWidth-1:0]  split_be;
    logic [NumWideBanks-1:0][NarrowPerWide-1:0][NarrowDataWidth-1:0]  split_rdata;

    // Flips every edge regardless of traffic
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            arb_narrow_q <= ArbNarrowFirst;
        end else begin
            arb_narrow_q <= ~arb_narrow_q;
        end
    end

    // ==================================================
    // Group arbitration and wide splitting
    // ==================================================
    for (genvar g = 0; g < NumWideBanks; g++) begin : gen_group
        // Any narrow requestor of this group competes with the wide port
        assign narrow_any[g] = |narrow_valid_i[g*NarrowPerWide +: NarrowPerWide];
        assign conflict[g] = narrow_any[g] & wide_valid_i[g];
        // Wide port is granted on all its lanes or not at all
        assign wide_ready[g] = conflict[g] ? ~arb_narrow_q : wide_valid_i[g];
        assign wide_grant[g] = wide_valid_i[g] & wide_ready[g];

        wide_to_narrow_splitter u_splitter (
            .clk_i        (clk_i),
            .rst_ni       (rst_ni),
            .wide_valid_i (wide_valid_i[g]),
            .wide_ready_i (wide_ready[g]),
            .wide_we_i    (wide_we_i[g]),
            .wide_addr_i  (wide_addr_i[g]),
            .wide_wdata_i (wide_wdata_i[g]),
            .wide_be_i    (wide_be_i[g]),
            .wide_rvalid_o(wide_rvalid_o[g]),
            .wide_rdata_o (wide_rdata_o[g]),
            .lane_we_o    (split_we[g]),
            .lane_addr_o  (split_addr[g]),
            .lane_wdata_o (split_wdata[g]),
            .lane_be_o    (split_be[g]),
            .lane_rdata_i (split_rdata[g])
        );
    end

    assign wide_ready_o = wide_ready;

    // ==================================================
    // Bank muxing and response routing
    // ==================================================
    for (genvar i = 0; i < NumNarrowBanks; i++) begin : gen_bank
        localparam int unsigned grp_idx = i / NarrowPerWide;
        localparam int unsigned lane_idx = i % NarrowPerWide;

        // Narrow readies of a group rise together when they win a conflict
        assign narrow_ready[i] = conflict[grp_idx] ? arb_narrow_q : narrow_valid_i[i];
        assign narrow_grant[i] = narrow_valid_i[i] & narrow_ready[i];
        assign wide_lane_grant[i] = wide_grant[grp_idx];

        // Strobe only on an accepted handshake, grants never overlap
        assign bank_req_o[i] = narrow_grant[i] | wide_lane_grant[i];

        always_comb begin
            if (narrow_grant[i]) begin
                bank_we_o[i] = narrow_we_i[i];
                bank_addr_o[i] = narrow_addr_i[i];
                bank_wdata_o[i] = narrow_wdata_i[i];
                bank_be_o[i] = narrow_be_i[i];
            end else begin
                // Wide lane by default, harmless while req is low
                bank_we_o[i] = split_we[grp_idx][lane_idx];
                bank_addr_o[i] = split_addr[grp_idx][lane_idx];
                bank_wdata_o[i] = split_wdata[grp_idx][lane_idx];
                bank_be_o[i] = split_be[grp_idx][lane_idx];
            end
        end

        // Remember which side owns next cycle's bank data
        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                narrow_sel_q[i] <= 1'b0;
                wide_sel_q[i] <= 1'b0;
            end else begin
                narrow_sel_q[i] <= narrow_grant[i];
                wide_sel_q[i] <= wide_lane_grant[i];
            end
        end

        // Unrouted side sees zero
        assign narrow_rdata_o[i] = narrow_sel_q[i] ? bank_rdata_i[i] : '0;
        assign split_rdata[grp_idx][lane_idx] = wide_sel_q[i] ? bank_rdata_i[i] : '0;
    end

    assign narrow_ready_o = narrow_ready;
    assign narrow_rvalid_o = narrow_sel_q;

endmodule

`default_nettype wire

//--- design/banked_mem_top.sv
/*
 * Banked scratchpad top level
 * Narrow/wide arbiter in front of one SRAM bank per narrow port
 */
`timescale 1ns/10ps
`default_nettype none

module banked_mem_top
    import lagd_mem_pkg::*;
(
    input  wire                                             clk_i,
    input  wire                                             rst_ni,
    // Narrow ports, one per bank
    input  wire  [NumNarrowBanks-1:0]                       narrow_valid_i,
    input  wire  [NumNarrowBanks-1:0]                       narrow_we_i,
    input  wire  [NumNarrowBanks-1:0][InBankAddrWidth-1:0]  narrow_addr_i,
    input  wire  [NumNarrowBanks-1:0][NarrowDataWidth-1:0]  narrow_wdata_i,
    input  wire  [NumNarrowBanks-1:0][NarrowStrbWidth-1:0]  narrow_be_i,
    output logic [NumNarrowBanks-1:0]                       narrow_ready_o,
    output logic [NumNarrowBanks-1:0]                       narrow_rvalid_o,
    output logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0]  narrow_rdata_o,
    // Wide ports, one per bank group
    input  wire  [NumWideBanks-1:0]                         wide_valid_i,
    input  wire  [NumWideBanks-1:0]                         wide_we_i,
    input  wire  [NumWideBanks-1:0][InBankAddrWidth-1:0]    wide_addr_i,
    input  wire  [NumWideBanks-1:0][WideDataWidth-1:0]      wide_wdata_i,
    input  wire  [NumWideBanks-1:0][WideStrbWidth-1:0]      wide_be_i,
    output logic [NumWideBanks-1:0]                         wide_ready_o,
    output logic [NumWideBanks-1:0]                         wide_rvalid_o,
    output logic [NumWideBanks-1:0][WideDataWidth-1:0]      wide_rdata_o
);

    // Arbiter to bank wiring
    logic [NumNarrowBanks-1:0]                       bank_req;
    logic [NumNarrowBanks-1:0]                       bank_we;
    logic [NumNarrowBanks-1:0][InBankAddrWidth-1:0]  bank_addr;
    logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0]  bank_wdata;
    logic [NumNarrowBanks-1:0][NarrowStrbWidth-1:0]  bank_be;
    logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0]  bank_rdata;

    wide_narrow_arbiter u_arbiter (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .narrow_valid_i (narrow_valid_i),
        .narrow_we_i    (narrow_we_i),
        .narrow_addr_i  (narrow_addr_i),
        .narrow_wdata_i (narrow_wdata_i),
        .narrow_be_i    (narrow_be_i),
        .narrow_ready_o (narrow_ready_o),
        .narrow_rvalid_o(narrow_rvalid_o),
        .narrow_rdata_o (narrow_rdata_o),
        .wide_valid_i   (wide_valid_i),
        .wide_we_i      (wide_we_i),
        .wide_addr_i    (wide_addr_i),
        .wide_wdata_i   (wide_wdata_i),
        .wide_be_i      (wide_be_i),
        .wide_ready_o   (wide_ready_o),
        .wide_rvalid_o  (wide_rvalid_o),
        .wide_rdata_o   (wide_rdata_o),
        .bank_req_o     (bank_req),
        .bank_we_o      (bank_we),
        .bank_addr_o    (bank_addr),
        .bank_wdata_o   (bank_wdata),
        .bank_be_o      (bank_be),
        .bank_rdata_i   (bank_rdata)
    );

    // One SRAM per narrow port
    for (genvar i = 0; i < NumNarrowBanks; i++) begin : gen_bank
        mem_bank u_bank (
            .clk_i  (clk_i),
            .rst_ni (rst_ni),
            .req_i  (bank_req[i]),
            .we_i   (bank_we[i]),
            .addr_i (bank_addr[i]),
            .wdata_i(bank_wdata[i]),
            .be_i   (bank_be[i]),
            .rdata_o(bank_rdata[i])
        );
    end

endmodule

`default_nettype wire

//--- bench/banked_mem_props.sv
/*
 * Concurrent assertions on the narrow/wide arbiter
 * Alternating priority bit, exclusive bank grants, one routed
 * response per bank request
 */
`timescale 1ns/10ps
`default_nettype none

module banked_mem_props
    import lagd_mem_pkg::*;
(
    input wire                       clk_i,
    input wire                       rst_ni,
    input wire                       arb_i,
    input wire [NumNarrowBanks-1:0]  narrow_grant_i,
    input wire [NumNarrowBanks-1:0]  wide_grant_i,
    input wire [NumNarrowBanks-1:0]  bank_req_i,
    input wire [NumNarrowBanks-1:0]  narrow_rvalid_i,
    input wire [NumWideBanks-1:0]    wide_rvalid_i
);

    // Wide response valid seen on every lane of its group
    logic [NumNarrowBanks-1:0] lane_rvalid;

    for (genvar i = 0; i < NumNarrowBanks; i++) begin : gen_lane
        assign lane_rvalid[i] = wide_rvalid_i[i / NarrowPerWide];
    end

    // Priority flips on every edge out of reset
    arb_alternates: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $past(rst_ni) |-> (arb_i != $past(arb_i)))
        else $error("Arbitration bit did not flip");

    // A bank serves one side per cycle
    grant_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (narrow_grant_i & wide_grant_i) == '0)
        else $error("Bank granted to narrow and wide side together");

    // Each bank request comes back as exactly one response valid next cycle
    one_response: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $past(rst_ni) |-> (((narrow_rvalid_i | lane_rvalid) == $past(bank_req_i))
                           && ((narrow_rvalid_i & lane_rvalid) == '0)))
        else $error("Bank request without exactly one routed response");

endmodule

bind wide_narrow_arbiter banked_mem_props u_props (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .arb_i          (arb_narrow_q),
    .narrow_grant_i (narrow_grant),
    .wide_grant_i   (wide_lane_grant),
    .bank_req_i     (bank_req_o),
    .narrow_rvalid_i(narrow_rvalid_o),
    .wide_rvalid_i  (wide_rvalid_o)
);

`default_nettype wire

//--- bench/banked_mem_tb.sv
/*
 * Testbench for the banked scratchpad
 * Clock, reset, LCG random traffic on all narrow and wide ports,
 * reference model of arbitration and bank contents, timeout
 */
`timescale 1ns/10ps
`default_nettype none

module banked_mem_tb
    import lagd_mem_pkg::*;
();

    // ==================================================
    // Run length and timeout
    // ==================================================
    localparam int unsigned ResetCycles = 5;
    localparam int unsigned RandomCycles = 2000;
    // Reset plus random phase plus margin
    localparam int unsigned TimeoutCycles = ResetCycles + RandomCycles + 95;

    logic clk_i;
    logic rst_ni;

    // DUT ports
    logic [NumNarrowBanks-1:0]                       narrow_valid;
    logic [NumNarrowBanks-1:0]                       narrow_we;
    logic [NumNarrowBanks-1:0][InBankAddrWidth-1:0]  narrow_addr;
    logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0]  narrow_wdata;
    logic [NumNarrowBanks-1:0][NarrowStrbWidth-1:0]  narrow_be;
    logic [NumNarrowBanks-1:0]                       narrow_ready;
    logic [NumNarrowBanks-1:0]                       narrow_rvalid;
    logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0]  narrow_rdata;
    logic [NumWideBanks-1:0]                         wide_valid;
    logic [NumWideBanks-1:0]                         wide_we;
    logic [NumWideBanks-1:0][InBankAddrWidth-1:0]    wide_addr;
    logic [NumWideBanks-1:0][WideDataWidth-1:0]      wide_wdata;
    logic [NumWideBanks-1:0][WideStrbWidth-1:0]      wide_be;
    logic [NumWideBanks-1:0]                         wide_ready;
    logic [NumWideBanks-1:0]                         wide_rvalid;
    logic [NumWideBanks-1:0][WideDataWidth-1:0]      wide_rdata;

    // Reference model state
    logic                                            arb_model;
    logic [NarrowDataWidth-1:0]                      shadow_mem [NumNarrowBanks][BankWords];
    // Bytes written at least once, only these are compared
    logic [NarrowDataWidth-1:0]                      known_mask [NumNarrowBanks][BankWords];
    logic [NumNarrowBanks-1:0]                       n_acc;
    logic [NumWideBanks-1:0]                         w_acc;
    logic [NumNarrowBanks-1:0]                       exp_nread;
    logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0]  exp_nrdata;
    logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0]  exp_nmask;
    logic [NumWideBanks-1:0]                         exp_wread;
    logic [NumWideBanks-1:0][WideDataWidth-1:0]      exp_wrdata;
    logic [NumWideBanks-1:0][WideDataWidth-1:0]      exp_wmask;
    // Conflict history per group for the starvation check
    logic [NumWideBanks-1:0]                         prev_conflict;
    logic [NumWideBanks-1:0]                         prev_wide_won;
    logic [31:0]                                     lcg_state;
    int unsigned                                     cycle_count;

    banked_mem_top DUT (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .narrow_valid_i (narrow_valid),
        .narrow_we_i    (narrow_we),
        .narrow_addr_i  (narrow_addr),
        .narrow_wdata_i (narrow_wdata),
        .narrow_be_i    (narrow_be),
        .narrow_ready_o (narrow_ready),
        .narrow_rvalid_o(narrow_rvalid),
        .narrow_rdata_o (narrow_rdata),
        .wide_valid_i   (wide_valid),
        .wide_we_i      (wide_we),
        .wide_addr_i    (wide_addr),
        .wide_wdata_i   (wide_wdata),
        .wide_be_i      (wide_be),
        .wide_ready_o   (wide_ready),
        .wide_rvalid_o  (wide_rvalid),
        .wide_rdata_o   (wide_rdata)
    );

    // 100 ns period
    always #50 clk_i = ~clk_i;

    // Ends a run that never reaches its final message
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TimeoutCycles) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("SOME TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

    // Numerical Recipes LCG
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_fail(input string name, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
        $display("Fail %s expected %h actual %h", name, exp_val, act_val);
        $display("SOME TESTS FAILED");
        $fatal(1, "Check failed");
    endtask

    // Byte-wise shadow update under the enables
    task automatic write_shadow(input int unsigned bank, input logic [InBankAddrWidth-1:0] a,
                                input logic [NarrowDataWidth-1:0] data,
                                input logic [NarrowStrbWidth-1:0] be);
        for (int b = 0; b < NarrowStrbWidth; b++) begin
            if (be[b]) begin
                shadow_mem[bank][a][b*8 +: 8] = data[b*8 +: 8];
                known_mask[bank][a][b*8 +: 8] = 8'hff;
            end
        end
    endtask

    // ==================================================
    // Stimulus
    // ==================================================
    // Refused requests are held, free ports may raise a new one
    task automatic drive_requests(input bit force_all);
        logic [31:0] r;
        for (int i = 0; i < NumNarrowBanks; i++) begin
            if (!narrow_valid[i] || n_acc[i]) begin
                r = lcg_next();
                narrow_valid[i] = force_all || (r[31:30] != 2'b00);
                narrow_we[i] = r[29];
                narrow_addr[i] = r[28:23];
                narrow_be[i] = r[22:19];
                narrow_wdata[i] = lcg_next();
            end
        end
        for (int g = 0; g < NumWideBanks; g++) begin
            if (!wide_valid[g] || w_acc[g]) begin
                r = lcg_next();
                wide_valid[g] = force_all || (r[31:30] != 2'b00);
                wide_we[g] = r[29];
                wide_addr[g] = r[28:23];
                wide_be[g] = r[22:15];
                wide_wdata[g] = {lcg_next(), lcg_next()};
            end
        end
    endtask

    // ==================================================
    // Model and checks
    // ==================================================
    // Readies against the arbitration rule, then record acceptances
    task automatic check_ready_and_accept();
        logic [NumWideBanks-1:0] conf;
        logic exp_r;
        int unsigned g;
        logic [InBankAddrWidth-1:0] a;
        for (int k = 0; k < NumWideBanks; k++) begin
            conf[k] = (narrow_valid[2*k] | narrow_valid[2*k+1]) & wide_valid[k];
            exp_r = conf[k] ? !arb_model : wide_valid[k];
            assert (wide_ready[k] === exp_r)
                else report_fail($sformatf("wide_ready[%0d]", k), 64'(exp_r), 64'(wide_ready[k]));
            // Two conflict cycles in a row must have different winners
            if (conf[k] && prev_conflict[k]) begin
                assert (wide_ready[k] !== prev_wide_won[k])
                    else report_fail($sformatf("no_starvation[%0d]", k),
                                     64'(!prev_wide_won[k]), 64'(wide_ready[k]));
            end
            prev_conflict[k] = conf[k];
            prev_wide_won[k] = wide_ready[k];
        end
        for (int i = 0; i < NumNarrowBanks; i++) begin
            g = i / NarrowPerWide;
            exp_r = conf[g] ? arb_model : narrow_valid[i];
            assert (narrow_ready[i] === exp_r)
                else report_fail($sformatf("narrow_ready[%0d]", i), 64'(exp_r),
                                 64'(narrow_ready[i]));
            n_acc[i] = narrow_valid[i] && narrow_ready[i];
            exp_nread[i] = n_acc[i] && !narrow_we[i];
            a = narrow_addr[i];
            exp_nrdata[i] = shadow_mem[i][a];
            exp_nmask[i] = known_mask[i][a];
            if (n_acc[i] && narrow_we[i]) begin
                write_shadow(i, a, narrow_wdata[i], narrow_be[i]);
            end
        end
        for (int k = 0; k < NumWideBanks; k++) begin
            w_acc[k] = wide_valid[k] && wide_ready[k];
            exp_wread[k] = w_acc[k] && !wide_we[k];
            a = wide_addr[k];
            // Lane 0 sits in the low half
            exp_wrdata[k] = {shadow_mem[2*k+1][a], shadow_mem[2*k][a]};
            exp_wmask[k] = {known_mask[2*k+1][a], known_mask[2*k][a]};
            if (w_acc[k] && wide_we[k]) begin
                write_shadow(2*k, a, wide_wdata[k][31:0], wide_be[k][3:0]);
                write_shadow(2*k+1, a, wide_wdata[k][63:32], wide_be[k][7:4]);
            end
        end
    endtask

    // Responses one cycle after acceptance, read data on known bytes
    task automatic check_responses();
        for (int i = 0; i < NumNarrowBanks; i++) begin
            assert (narrow_rvalid[i] === n_acc[i])
                else report_fail($sformatf("narrow_rvalid[%0d]", i), 64'(n_acc[i]),
                                 64'(narrow_rvalid[i]));
            if (exp_nread[i]) begin
                assert (((narrow_rdata[i] ^ exp_nrdata[i]) & exp_nmask[i]) === '0)
                    else report_fail($sformatf("narrow_rdata[%0d]", i), 64'(exp_nrdata[i]),
                                     64'(narrow_rdata[i]));
            end
        end
        for (int k = 0; k < NumWideBanks; k++) begin
            assert (wide_rvalid[k] === w_acc[k])
                else report_fail($sformatf("wide_rvalid[%0d]", k), 64'(w_acc[k]),
                                 64'(wide_rvalid[k]));
            if (exp_wread[k]) begin
                assert (((wide_rdata[k] ^ exp_wrdata[k]) & exp_wmask[k]) === '0)
                    else report_fail($sformatf("wide_rdata[%0d]", k), exp_wrdata[k],
                                     wide_rdata[k]);
            end
        end
    endtask

    initial begin
        clk_i = 1'b0;
        rst_ni = 1'b0;
        cycle_count = 0;
        lcg_state = 32'hd9c9_f424;
        arb_model = ArbNarrowFirst;
        narrow_valid = '0;
        narrow_we = '0;
        narrow_addr = '0;
        narrow_wdata = '0;
        narrow_be = '0;
        wide_valid = '0;
        wide_we = '0;
        wide_addr = '0;
        wide_wdata = '0;
        wide_be = '0;
        n_acc = '0;
        w_acc = '0;
        exp_nread = '0;
        exp_wread = '0;
        prev_conflict = '0;
        prev_wide_won = '0;
        for (int b = 0; b < NumNarrowBanks; b++) begin
            for (int w = 0; w < BankWords; w++) begin
                known_mask[b][w] = '0;
            end
        end

        // No response may appear during reset
        repeat (ResetCycles) begin
            @(posedge clk_i);
            #1;
            check_responses();
        end
        rst_ni = 1'b1;

        // First cycle raises every request to force a conflict on the reset priority
        for (int c = 0; c < RandomCycles; c++) begin
            drive_requests(c == 0);
            @(negedge clk_i);
            check_ready_and_accept();
            @(posedge clk_i);
            #1;
            arb_model = ~arb_model;
            check_responses();
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
design/lagd_mem_pkg.sv
design/mem_bank.sv
design/wide_to_narrow_splitter.sv
design/wide_narrow_arbiter.sv
design/banked_mem_top.sv
bench/banked_mem_props.sv
bench/banked_mem_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the banked scratchpad testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module banked_mem_tb -f list.f -o banked_mem_sim \
    && ./obj_dir/banked_mem_sim > sim.log 2>&1 \
    || echo "Build or simulation returned an error"

cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }
